// File: tb.f
rtl/concat_pkg.sv
rtl/concat_stream_if.sv
rtl/map_ingress.sv
rtl/feature_fifo.sv
rtl/concat_2in.sv
rtl/concat_egress.sv
rtl/concat_top.sv
bench/tb_concat_top.sv

// File: Makefile
# Verilator build and run for the concat testbench

VERILATOR ?= verilator
TOP       ?= tb_concat_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --timescale $(TIMESCALE)
PASS_TEXT ?= sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Output goes to the terminal and the pass line is searched for in it
run: compile
	@result="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$result"; \
	echo "$$result" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/tb_concat_top.sv
`timescale 1ns/1ps

module tb_concat_top;

  localparam int W               = concat_pkg::DATA_WIDTH;
  localparam int PIXELS          = concat_pkg::MAP_PIXELS;
  // Words sent on A beyond one map in the overrun test
  localparam int EXTRA_A         = 3;
  localparam int TEST_COUNT      = 5;
  localparam int CYCLES_PER_TEST = 200;
  localparam int RESET_CYCLES    = 4;
  // Frames over all tests with three in the repeat test
  localparam int TOTAL_FRAMES    = 7;

  logic         clk;
  logic         reset;
  logic         valid_in_a;
  logic [W-1:0] in_a;
  logic         valid_in_b;
  logic [W-1:0] in_b;
  logic [W-1:0] out;
  logic         valid_out;
  logic         out_source;
  logic         frame_done;
  logic         overrun;

  // Expected A words come out before any expected B word
  logic [W-1:0] exp_a [$];
  logic [W-1:0] exp_b [$];

  // Words of the frame being sent
  logic [W-1:0] words_a [PIXELS + EXTRA_A];
  logic [W-1:0] words_b [PIXELS];

  logic [15:0]  lfsr_state;
  int           error_count;
  int           check_count;
  int           frames_seen;

  concat_top concat_top_i (
    .clk        (clk),
    .reset      (reset),
    .valid_in_a (valid_in_a),
    .in_a       (in_a),
    .valid_in_b (valid_in_b),
    .in_b       (in_b),
    .out        (out),
    .valid_out  (valid_out),
    .out_source (out_source),
    .frame_done (frame_done),
    .overrun    (overrun)
  );

  // 100 ns period
  always #50 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  // One input cycle on both map ports
  task automatic drive_inputs(input logic va, input logic [W-1:0] da,
                              input logic vb, input logic [W-1:0] db);
    @(posedge clk);
    valid_in_a <= va;
    in_a       <= da;
    valid_in_b <= vb;
    in_b       <= db;
  endtask

  task automatic drive_idle();
    drive_inputs(1'b0, '0, 1'b0, '0);
  endtask

  // Galois LFSR stepped once per bit taken
  function automatic logic [W-1:0] next_random_word();
    logic [W-1:0] word;
    word = '0;
    for (int i = 0; i < W; i++) begin
      if (lfsr_state[0]) begin
        lfsr_state = (lfsr_state >> 1) ^ 16'hB400;
      end else begin
        lfsr_state = lfsr_state >> 1;
      end
      word = {word[W-2:0], lfsr_state[0]};
    end
    return word;
  endfunction

  task automatic fill_random_frame();
    for (int i = 0; i < PIXELS + EXTRA_A; i++) begin
      words_a[i] = next_random_word();
    end
    for (int i = 0; i < PIXELS; i++) begin
      words_b[i] = next_random_word();
    end
  endtask

  // Only the first map's worth of A ever comes out
  task automatic queue_expected();
    for (int i = 0; i < PIXELS; i++) begin
      exp_a.push_back(words_a[i]);
      exp_b.push_back(words_b[i]);
    end
  endtask

  task automatic wait_frames(input int target);
    while (frames_seen < target) begin
      @(posedge clk);
    end
  endtask

  task automatic check_frame_closed(input string test_name);
    check_count++;
    if (exp_a.size() != 0 || exp_b.size() != 0) begin
      $display("ERROR: %s: %0d A and %0d B words never came out",
               test_name, exp_a.size(), exp_b.size());
      error_count++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Output monitor
  //////////////////////////////////////////////////////////////////////

  // Sampled on the falling edge between driving edges
  task automatic watch_outputs();
    logic [W-1:0] exp_word;
    logic         exp_source;
    logic         exp_done;
    forever begin
      @(negedge clk);
      if (!reset) begin
        if (valid_out) begin
          if (exp_a.size() == 0 && exp_b.size() == 0) begin
            $display("ERROR: time %0t: output word %h with nothing expected", $time, out);
            error_count++;
          end else begin
            if (exp_a.size() > 0) begin
              exp_word   = exp_a.pop_front();
              exp_source = 1'b0;
            end else begin
              exp_word   = exp_b.pop_front();
              exp_source = 1'b1;
            end
            // Frame ends on the final queued word
            exp_done = (exp_a.size() == 0) && (exp_b.size() == 0);
            check_count++;
            if (out !== exp_word) begin
              $display("MISMATCH time %0t out: expected %h got %h", $time, exp_word, out);
              error_count++;
            end
            if (out_source !== exp_source) begin
              $display("MISMATCH time %0t out_source: expected %b got %b",
                       $time, exp_source, out_source);
              error_count++;
            end
            if (frame_done !== exp_done) begin
              $display("MISMATCH time %0t frame_done: expected %b got %b",
                       $time, exp_done, frame_done);
              error_count++;
            end
          end
        end else if (frame_done) begin
          $display("ERROR: time %0t: frame_done high without a valid word", $time);
          error_count++;
        end
        if (frame_done === 1'b1) begin
          frames_seen++;
        end
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  // All of A and then all of B
  task automatic test_basic_frame();
    int target;
    target = frames_seen + 1;
    for (int i = 0; i < PIXELS; i++) begin
      words_a[i] = 32'hA000_0000 | i;
      words_b[i] = 32'hB000_0000 | i;
    end
    queue_expected();
    for (int i = 0; i < PIXELS; i++) begin
      drive_inputs(1'b1, words_a[i], 1'b0, '0);
    end
    for (int i = 0; i < PIXELS; i++) begin
      drive_inputs(1'b0, '0, 1'b1, words_b[i]);
    end
    drive_idle();
    wait_frames(target);
    check_frame_closed("basic frame");
  endtask

  // Half of B rides along with A before A has filled
  task automatic test_early_b();
    int target;
    int bi;
    target = frames_seen + 1;
    bi     = 0;
    fill_random_frame();
    queue_expected();
    for (int i = 0; i < PIXELS; i++) begin
      if (i % 2 == 1) begin
        drive_inputs(1'b1, words_a[i], 1'b1, words_b[bi]);
        bi++;
      end else begin
        drive_inputs(1'b1, words_a[i], 1'b0, '0);
      end
    end
    while (bi < PIXELS) begin
      drive_inputs(1'b0, '0, 1'b1, words_b[bi]);
      bi++;
    end
    drive_idle();
    wait_frames(target);
    check_frame_closed("early B");
  endtask

  // B trickles in after A is gone
  task automatic test_late_b();
    int target;
    target = frames_seen + 1;
    fill_random_frame();
    queue_expected();
    for (int i = 0; i < PIXELS; i++) begin
      drive_inputs(1'b1, words_a[i], 1'b0, '0);
    end
    drive_idle();
    while (exp_a.size() > 0) begin
      @(posedge clk);
    end
    for (int i = 0; i < PIXELS; i++) begin
      if (i == PIXELS - 1) begin
        // Wait for every earlier B word to come out
        while (exp_b.size() > 1) begin
          @(posedge clk);
        end
        // Frame stays open until the last B word
        check_count++;
        if (frames_seen != target - 1) begin
          $display("ERROR: late B: frame ended before the last B word was sent");
          error_count++;
        end
      end
      drive_inputs(1'b0, '0, 1'b1, words_b[i]);
      // Two idle cycles between B words
      drive_idle();
      drive_idle();
    end
    wait_frames(target);
    check_frame_closed("late B");
  endtask

  // Three words too many on A
  task automatic test_overrun();
    int target;
    target = frames_seen + 1;
    @(negedge clk);
    check_count++;
    if (overrun !== 1'b0) begin
      $display("MISMATCH time %0t overrun: expected 0 got %b", $time, overrun);
      error_count++;
    end
    fill_random_frame();
    queue_expected();
    for (int i = 0; i < PIXELS + EXTRA_A; i++) begin
      drive_inputs(1'b1, words_a[i], 1'b0, '0);
    end
    drive_idle();
    @(negedge clk);
    check_count++;
    if (overrun !== 1'b1) begin
      $display("MISMATCH time %0t overrun: expected 1 got %b", $time, overrun);
      error_count++;
    end
    for (int i = 0; i < PIXELS; i++) begin
      drive_inputs(1'b0, '0, 1'b1, words_b[i]);
    end
    drive_idle();
    wait_frames(target);
    check_frame_closed("overrun");
    // Sticky flag
    check_count++;
    if (overrun !== 1'b1) begin
      $display("MISMATCH time %0t overrun: expected 1 got %b", $time, overrun);
      error_count++;
    end
  endtask

  // Three frames sent one right after another
  task automatic test_repeated_frames();
    int start;
    start = frames_seen;
    for (int f = 0; f < 3; f++) begin
      fill_random_frame();
      queue_expected();
      for (int i = 0; i < PIXELS; i++) begin
        drive_inputs(1'b1, words_a[i], 1'b1, words_b[i]);
      end
      drive_idle();
      wait_frames(start + f + 1);
      check_frame_closed("repeated frames");
    end
    // Room for a stray extra pulse to show up
    repeat (8) drive_idle();
    check_count++;
    if (frames_seen != start + 3) begin
      $display("MISMATCH time %0t frame_done count: expected %0d got %0d",
               $time, 3, frames_seen - start);
      error_count++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    valid_in_a  = 1'b0;
    in_a        = '0;
    valid_in_b  = 1'b0;
    in_b        = '0;
    lfsr_state  = 16'd42964;
    error_count = 0;
    check_count = 0;
    frames_seen = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    fork
      watch_outputs();
    join_none
    test_basic_frame();
    test_early_b();
    test_late_b();
    test_overrun();
    test_repeated_frames();
    check_count++;
    if (frames_seen != TOTAL_FRAMES) begin
      $display("ERROR: saw %0d frames, expected %0d", frames_seen, TOTAL_FRAMES);
      error_count++;
    end
    $display("errors: %0d  checks: %0d  frames: %0d", error_count, check_count, frames_seen);
    if (error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // About 200 cycles per test
  initial begin
    repeat (RESET_CYCLES + TEST_COUNT * CYCLES_PER_TEST) @(posedge clk);
    $display("ERROR: timeout, run did not finish in %0d cycles",
             RESET_CYCLES + TEST_COUNT * CYCLES_PER_TEST);
    $display("errors: %0d  checks: %0d  frames: %0d", error_count, check_count, frames_seen);
    $display("sim failed");
    $finish;
  end

endmodule

// File: rtl/concat_top.sv
`timescale 1ns/1ps

module concat_top (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              valid_in_a,
  input  logic [concat_pkg::DATA_WIDTH-1:0] in_a,
  input  logic                              valid_in_b,
  input  logic [concat_pkg::DATA_WIDTH-1:0] in_b,
  output logic [concat_pkg::DATA_WIDTH-1:0] out,
  output logic                              valid_out,
  output logic                              out_source,
  output logic                              frame_done,
  output logic                              overrun
);

  // Ingress to core
  logic                              write_a;
  logic [concat_pkg::DATA_WIDTH-1:0] data_a;
  logic                              write_b;
  logic [concat_pkg::DATA_WIDTH-1:0] data_b;

  // Core back to ingress
  logic                              frame_end;

  // Core to egress
  concat_stream_if merged ();

  //////////////////////////////////////////////////////////////////////
  // Input side
  //////////////////////////////////////////////////////////////////////

  map_ingress map_ingress_i (
    .clk        (clk),
    .reset      (reset),
    .valid_in_a (valid_in_a),
    .in_a       (in_a),
    .valid_in_b (valid_in_b),
    .in_b       (in_b),
    .frame_end  (frame_end),
    .write_a    (write_a),
    .data_a     (data_a),
    .write_b    (write_b),
    .data_b     (data_b),
    .overrun    (overrun)
  );

  //////////////////////////////////////////////////////////////////////
  // Buffering and A-then-B sequencing
  //////////////////////////////////////////////////////////////////////

  concat_2in concat_2in_i (
    .clk       (clk),
    .reset     (reset),
    .write_a   (write_a),
    .data_a    (data_a),
    .write_b   (write_b),
    .data_b    (data_b),
    .merged    (merged.core),
    .frame_end (frame_end)
  );

  //////////////////////////////////////////////////////////////////////
  // Output side
  //////////////////////////////////////////////////////////////////////

  concat_egress concat_egress_i (
    .clk        (clk),
    .reset      (reset),
    .merged     (merged.egress),
    .out        (out),
    .valid_out  (valid_out),
    .out_source (out_source),
    .frame_done (frame_done)
  );

endmodule

// File: rtl/concat_egress.sv
`timescale 1ns/1ps

module concat_egress (
  input  logic                              clk,
  input  logic                              reset,
  concat_stream_if.egress                   merged,
  output logic [concat_pkg::DATA_WIDTH-1:0] out,
  output logic                              valid_out,
  output logic                              out_source,
  output logic                              frame_done
);

  //////////////////////////////////////////////////////////////////////
  // Control outputs
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_out  <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      valid_out  <= merged.valid;
      // Lines up with the final valid word of the frame
      frame_done <= merged.valid && merged.last;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Word and tag
  //////////////////////////////////////////////////////////////////////

  // Held at the last word while nothing is valid
  always_ff @(posedge clk) begin
    if (merged.valid) begin
      out        <= merged.data;
      out_source <= merged.source;
    end
  end

endmodule

// File: rtl/concat_2in.sv
`timescale 1ns/1ps

module concat_2in (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              write_a,
  input  logic [concat_pkg::DATA_WIDTH-1:0] data_a,
  input  logic                              write_b,
  input  logic [concat_pkg::DATA_WIDTH-1:0] data_b,
  concat_stream_if.core                     merged,
  output logic                              frame_end
);

  logic                              read_phase;
  logic                              read_a;
  logic                              read_b;
  logic [concat_pkg::DATA_WIDTH-1:0] fifo_a_data;
  logic [concat_pkg::DATA_WIDTH-1:0] fifo_b_data;
  logic                              fifo_a_valid;
  logic                              fifo_b_valid;
  logic                              fifo_a_empty;
  logic                              fifo_a_full;
  logic [concat_pkg::PTR_WIDTH-1:0]  b_count;
  logic [concat_pkg::PTR_WIDTH-1:0]  b_count_next;
  logic                              b_final;

  //////////////////////////////////////////////////////////////////////
  // Map buffers
  //////////////////////////////////////////////////////////////////////

  feature_fifo #(
    .WIDTH (concat_pkg::DATA_WIDTH),
    .DEPTH (concat_pkg::FIFO_DEPTH)
  ) fifo_a (
    .clk       (clk),
    .reset     (reset),
    .write     (write_a),
    .read      (read_a),
    .data_in   (data_a),
    .data_out  (fifo_a_data),
    .valid_out (fifo_a_valid),
    .empty     (fifo_a_empty),
    .full      (fifo_a_full)
  );

  // B status flags not needed, the ingress caps B at one map
  feature_fifo #(
    .WIDTH (concat_pkg::DATA_WIDTH),
    .DEPTH (concat_pkg::FIFO_DEPTH)
  ) fifo_b (
    .clk       (clk),
    .reset     (reset),
    .write     (write_b),
    .read      (read_b),
    .data_in   (data_b),
    .data_out  (fifo_b_data),
    .valid_out (fifo_b_valid),
    .empty     (),
    .full      ()
  );

  // A drains every cycle of the read phase
  assign read_a = read_phase;
  // B only once A is drained, never before A has filled
  assign read_b = read_phase && fifo_a_empty;

  // Final B word of the frame leaving the FIFO
  assign b_count_next = b_count + 1'b1;
  assign b_final      = fifo_b_valid && !fifo_a_valid &&
                        (b_count_next == concat_pkg::MAP_COUNT);

  //////////////////////////////////////////////////////////////////////
  // Read phase
  //////////////////////////////////////////////////////////////////////

  // Set the cycle after A shows full, cleared when the frame closes
  always_ff @(posedge clk) begin
    if (reset) begin
      read_phase <= 1'b0;
    end else if (b_final) begin
      read_phase <= 1'b0;
    end else if (fifo_a_full) begin
      read_phase <= 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Output register and B counter
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      merged.valid <= 1'b0;
      merged.last  <= 1'b0;
      b_count      <= '0;
    end else begin
      merged.last <= b_final;
      // A wins over B
      if (fifo_a_valid) begin
        merged.valid <= 1'b1;
      end else if (fifo_b_valid) begin
        merged.valid <= 1'b1;
        // Restart for the next frame
        b_count      <= b_final ? '0 : b_count_next;
      end else begin
        merged.valid <= 1'b0;
      end
    end
  end

  // Payload and source tag
  always_ff @(posedge clk) begin
    if (fifo_a_valid) begin
      merged.data   <= fifo_a_data;
      merged.source <= 1'b0;
    end else if (fifo_b_valid) begin
      merged.data   <= fifo_b_data;
      merged.source <= 1'b1;
    end
  end

  // Pulse back to ingress to clear the map counts
  assign frame_end = merged.last;

endmodule

// File: rtl/feature_fifo.sv
`timescale 1ns/1ps

module feature_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 16
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             write,
  input  logic             read,
  input  logic [WIDTH-1:0] data_in,
  output logic [WIDTH-1:0] data_out,
  output logic             valid_out,
  output logic             empty,
  output logic             full
);

  // At least one address bit, even for a single entry
  localparam int ADDR_WIDTH  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

  logic [WIDTH-1:0]       mem [DEPTH];
  logic [ADDR_WIDTH-1:0]  wr_ptr;
  logic [ADDR_WIDTH-1:0]  rd_ptr;
  logic [COUNT_WIDTH-1:0] count;
  logic                   do_write;
  logic                   do_read;

  //////////////////////////////////////////////////////////////////////
  // Status
  //////////////////////////////////////////////////////////////////////

  // Straight from the occupancy count
  assign empty = (count == '0);
  assign full  = (count == COUNT_WIDTH'(DEPTH));

  // Write while full is ignored
  assign do_write = write && !full;
  // Read of an empty buffer does nothing
  assign do_read  = read && !empty;

  //////////////////////////////////////////////////////////////////////
  // Pointers and count
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      valid_out <= 1'b0;
    end else begin
      // Wrap at DEPTH, not at a power of two
      if (do_write) begin
        if (wr_ptr == ADDR_WIDTH'(DEPTH - 1)) begin
          wr_ptr <= '0;
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
      if (do_read) begin
        if (rd_ptr == ADDR_WIDTH'(DEPTH - 1)) begin
          rd_ptr <= '0;
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // One pulse per word handed out
      valid_out <= do_read;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_ptr] <= data_in;
    end
  end

  // Registered read data, held between reads
  always_ff @(posedge clk) begin
    if (do_read) begin
      data_out <= mem[rd_ptr];
    end
  end

endmodule

// File: rtl/map_ingress.sv
`timescale 1ns/1ps

module map_ingress (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              valid_in_a,
  input  logic [concat_pkg::DATA_WIDTH-1:0] in_a,
  input  logic                              valid_in_b,
  input  logic [concat_pkg::DATA_WIDTH-1:0] in_b,
  input  logic                              frame_end,
  output logic                              write_a,
  output logic [concat_pkg::DATA_WIDTH-1:0] data_a,
  output logic                              write_b,
  output logic [concat_pkg::DATA_WIDTH-1:0] data_b,
  output logic                              overrun
);

  // Index 0 is map A, index 1 is map B
  logic [1:0]                        valid_in;
  logic [concat_pkg::DATA_WIDTH-1:0] word_in [2];
  logic [concat_pkg::PTR_WIDTH-1:0]  count [2];
  logic [concat_pkg::PTR_WIDTH-1:0]  count_now [2];
  logic [1:0]                        accept;
  logic [1:0]                        drop;
  logic [1:0]                        write_q;
  logic [concat_pkg::DATA_WIDTH-1:0] data_q [2];

  assign valid_in   = {valid_in_b, valid_in_a};
  assign word_in[0] = in_a;
  assign word_in[1] = in_b;

  //////////////////////////////////////////////////////////////////////
  // Per-map admission
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int m = 0; m < 2; m++) begin
      // Frame end restarts the count in this very cycle
      // so a word of the next frame is not lost
      count_now[m] = frame_end ? '0 : count[m];
      accept[m]    = valid_in[m] && (count_now[m] != concat_pkg::MAP_COUNT);
      // Map already complete for this frame
      drop[m]      = valid_in[m] && (count_now[m] == concat_pkg::MAP_COUNT);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      count[0] <= '0;
      count[1] <= '0;
      write_q  <= '0;
      overrun  <= 1'b0;
    end else begin
      for (int m = 0; m < 2; m++) begin
        if (accept[m]) begin
          count[m] <= count_now[m] + 1'b1;
        end else begin
          count[m] <= count_now[m];
        end
      end
      write_q <= accept;
      // Sticky until reset
      if (|drop) begin
        overrun <= 1'b1;
      end
    end
  end

  // Word capture, one cycle behind the input strobe
  always_ff @(posedge clk) begin
    for (int m = 0; m < 2; m++) begin
      if (accept[m]) begin
        data_q[m] <= word_in[m];
      end
    end
  end

  assign write_a = write_q[0];
  assign data_a  = data_q[0];
  assign write_b = write_q[1];
  assign data_b  = data_q[1];

endmodule

// File: rtl/concat_stream_if.sv
`timescale 1ns/1ps

// Merged A-then-B word stream between the concat core and the output side
interface concat_stream_if;

  // One word per cycle while high
  logic                              valid;

  // Feature word
  logic [concat_pkg::DATA_WIDTH-1:0] data;

  // Origin of the word
  // 0 for map A, 1 for map B
  logic                              source;

  // Final B word of the frame
  logic                              last;

  // Core side drives the stream
  modport core (
    output valid,
    output data,
    output source,
    output last
  );

  // Output side only samples it
  modport egress (
    input valid,
    input data,
    input source,
    input last
  );

endinterface

// File: rtl/concat_pkg.sv
package concat_pkg;

  //////////////////////////////////////////////////////////////////////
  // Word format
  //////////////////////////////////////////////////////////////////////

  // Width of one feature word
  localparam int DATA_WIDTH = 32;

  //////////////////////////////////////////////////////////////////////
  // Map geometry
  //////////////////////////////////////////////////////////////////////

  // Words in one map per frame
  // Kept small so a frame simulates quickly
  localparam int MAP_PIXELS = 16;

  // Pointer and counter width
  // One extra bit so the full count fits
  localparam int PTR_WIDTH = $clog2(MAP_PIXELS) + 1;

  // Each map FIFO holds one whole map
  localparam int FIFO_DEPTH = MAP_PIXELS;

  // Full map count at counter width
  // Compared against the per-map word counters
  localparam logic [PTR_WIDTH-1:0] MAP_COUNT = PTR_WIDTH'(MAP_PIXELS);

endpackage
